/* rtl/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and address width
`define CPU_WORD_SIZE 16

// Architectural register count
`define CPU_NUM_REGS 4

// Register address width
`define CPU_REG_ADDR_W $clog2(`CPU_NUM_REGS)

// First fetch address after reset
`define CPU_RESET_PC 0

`endif

/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_PASSB,
        ALU_EQ,
        ALU_NE
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } i_fmt_t;

    // One instruction word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    dest_is_rt;
        logic    is_branch;
        logic    is_jump;
        logic    wwd;
        logic    halt;
    } ctrl_t;

    // Operand forwarding selects
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_WB  = 2'd1;
    localparam logic [1:0] FWD_MEM = 2'd2;

endpackage

`default_nettype wire

/* rtl/regfile_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

interface regfile_if;

    logic [`CPU_REG_ADDR_W-1:0] rs_addr;
    logic [`CPU_REG_ADDR_W-1:0] rt_addr;
    logic [`CPU_WORD_SIZE-1:0]  rs_data;
    logic [`CPU_WORD_SIZE-1:0]  rt_data;
    logic                       wr_en;
    logic [`CPU_REG_ADDR_W-1:0] wr_addr;
    logic [`CPU_WORD_SIZE-1:0]  wr_data;

    modport pipe_side (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input  rs_data, rt_data
    );

    modport reg_side (
        input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_data, rt_data
    );

endinterface

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
    input logic         clk,
    input logic         reset_n,
    regfile_if.reg_side rf
);

    logic [`CPU_WORD_SIZE-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // Write-first: a WB write is visible to ID in the same cycle
    assign rf.rs_data = (rf.wr_en && rf.wr_addr == rf.rs_addr) ? rf.wr_data
                                                               : regs[rf.rs_addr];
    assign rf.rt_data = (rf.wr_en && rf.wr_addr == rf.rt_addr) ? rf.wr_data
                                                               : regs[rf.rt_addr];

    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (reset_n)
        rf.wr_en |-> !$isunknown(rf.wr_addr)
    ) else $error("register write with unknown address %b", rf.wr_addr);

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module control_unit (
    input  cpu_pkg::instr_t           instr,
    output cpu_pkg::ctrl_t            ctrl,
    output logic [`CPU_WORD_SIZE-1:0] imm_ext
);

    import cpu_pkg::*;

    always_comb begin
        ctrl    = '0;
        imm_ext = {{(`CPU_WORD_SIZE-8){instr.i.imm[7]}}, instr.i.imm};
        case (instr.i.opcode)
            OP_RTYPE: begin
                imm_ext = '0;
                case (instr.r.funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_ORR: ctrl.alu_op = ALU_ORR;
                    default: ;
                endcase
                ctrl.reg_write = (instr.r.funct inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});
                // rs + 0 carries the port value down to WB
                ctrl.alu_src_imm = (instr.r.funct == FN_WWD);
                ctrl.wwd         = (instr.r.funct == FN_WWD);
                ctrl.halt        = (instr.r.funct == FN_HLT);
            end
            OP_ADI, OP_LWD: begin
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.dest_is_rt  = 1'b1;
                ctrl.mem_read    = (instr.i.opcode == OP_LWD);
            end
            OP_LHI: begin
                imm_ext          = `CPU_WORD_SIZE'({instr.i.imm, 8'h00});
                ctrl.alu_op      = ALU_PASSB;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.dest_is_rt  = 1'b1;
            end
            OP_SWD: begin
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op    = (instr.i.opcode == OP_BEQ) ? ALU_EQ : ALU_NE;
                ctrl.is_branch = 1'b1;
            end
            OP_JMP: begin
                imm_ext      = `CPU_WORD_SIZE'({instr.i.rs, instr.i.rt, instr.i.imm});
                ctrl.is_jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/hazard_forward.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module hazard_forward (
    input  cpu_pkg::instr_t            id_instr,
    input  logic                       ex_mem_read,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_dest,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_rs,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_rt,
    input  logic                       mem_reg_write,
    input  logic [`CPU_REG_ADDR_W-1:0] mem_dest,
    input  logic                       wb_reg_write,
    input  logic [`CPU_REG_ADDR_W-1:0] wb_dest,
    output logic                       stall,
    output logic [1:0]                 fwd_a,
    output logic [1:0]                 fwd_b
);

    import cpu_pkg::*;

    // Load in EX feeding the instruction in ID
    assign stall = ex_mem_read && (ex_dest == id_instr.i.rs || ex_dest == id_instr.i.rt);

    // The younger result in MEM wins over WB
    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (mem_reg_write && mem_dest == ex_rs) begin
            fwd_a = FWD_MEM;
        end else if (wb_reg_write && wb_dest == ex_rs) begin
            fwd_a = FWD_WB;
        end
        if (mem_reg_write && mem_dest == ex_rt) begin
            fwd_b = FWD_MEM;
        end else if (wb_reg_write && wb_dest == ex_rt) begin
            fwd_b = FWD_WB;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  cpu_pkg::alu_op_e          op,
    input  logic [`CPU_WORD_SIZE-1:0] a,
    input  logic [`CPU_WORD_SIZE-1:0] b,
    output logic [`CPU_WORD_SIZE-1:0] result,
    output logic                      cond
);

    import cpu_pkg::*;

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_ORR:   result = a | b;
            ALU_PASSB: result = b;
            // Branch compares only drive cond
            ALU_EQ:    cond = (a == b);
            ALU_NE:    cond = (a != b);
            default:   ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cpu_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_pipeline (
    input  logic                      clk,
    input  logic                      reset_n,
    regfile_if.pipe_side              rf,
    output logic                      read_m1,
    output logic [`CPU_WORD_SIZE-1:0] address1,
    input  logic [`CPU_WORD_SIZE-1:0] data1,
    output logic                      read_m2,
    output logic                      write_m2,
    output logic [`CPU_WORD_SIZE-1:0] address2,
    input  logic [`CPU_WORD_SIZE-1:0] rdata2,
    output logic [`CPU_WORD_SIZE-1:0] wdata2,
    output logic [`CPU_WORD_SIZE-1:0] num_inst,
    output logic [`CPU_WORD_SIZE-1:0] output_port,
    output logic                      is_halted
);

    import cpu_pkg::*;

    logic [`CPU_WORD_SIZE-1:0]  pc;
    logic                       halted_q;

    logic                       if_id_valid;
    instr_t                     if_id_instr;
    logic [`CPU_WORD_SIZE-1:0]  if_id_pc1;

    ctrl_t                      dec_ctrl;
    ctrl_t                      id_ctrl;
    logic [`CPU_WORD_SIZE-1:0]  id_imm;
    logic [`CPU_REG_ADDR_W-1:0] id_dest;
    logic                       stall;

    ctrl_t                      id_ex_ctrl;
    logic [`CPU_WORD_SIZE-1:0]  id_ex_pc1;
    logic [`CPU_WORD_SIZE-1:0]  id_ex_imm;
    logic [`CPU_WORD_SIZE-1:0]  id_ex_rs_data;
    logic [`CPU_WORD_SIZE-1:0]  id_ex_rt_data;
    logic [`CPU_REG_ADDR_W-1:0] id_ex_rs;
    logic [`CPU_REG_ADDR_W-1:0] id_ex_rt;
    logic [`CPU_REG_ADDR_W-1:0] id_ex_dest;

    logic [1:0]                 fwd_a;
    logic [1:0]                 fwd_b;
    logic [`CPU_WORD_SIZE-1:0]  ex_a;
    logic [`CPU_WORD_SIZE-1:0]  ex_b_reg;
    logic [`CPU_WORD_SIZE-1:0]  ex_b;
    logic [`CPU_WORD_SIZE-1:0]  ex_result;
    logic [`CPU_WORD_SIZE-1:0]  ex_target;
    logic                       ex_cond;
    logic                       ex_taken;

    ctrl_t                      ex_mem_ctrl;
    logic [`CPU_WORD_SIZE-1:0]  ex_mem_result;
    logic [`CPU_WORD_SIZE-1:0]  ex_mem_store;
    logic [`CPU_REG_ADDR_W-1:0] ex_mem_dest;

    ctrl_t                      mem_wb_ctrl;
    logic [`CPU_WORD_SIZE-1:0]  mem_wb_result;
    logic [`CPU_REG_ADDR_W-1:0] mem_wb_dest;

    //////////////////////////////////////////////////////////////////////
    // IF and ID

    assign read_m1  = !is_halted;
    assign address1 = pc;

    control_unit u_control (
        .instr   (if_id_instr),
        .ctrl    (dec_ctrl),
        .imm_ext (id_imm)
    );

    assign id_ctrl      = if_id_valid ? dec_ctrl : '0;
    assign id_dest      = id_ctrl.dest_is_rt ? if_id_instr.i.rt : if_id_instr.r.rd;
    assign rf.rs_addr   = if_id_instr.i.rs;
    assign rf.rt_addr   = if_id_instr.i.rt;

    hazard_forward u_hazard (
        .id_instr      (if_id_instr),
        .ex_mem_read   (id_ex_ctrl.mem_read),
        .ex_dest       (id_ex_dest),
        .ex_rs         (id_ex_rs),
        .ex_rt         (id_ex_rt),
        .mem_reg_write (ex_mem_ctrl.reg_write),
        .mem_dest      (ex_mem_dest),
        .wb_reg_write  (mem_wb_ctrl.reg_write),
        .wb_dest       (mem_wb_dest),
        .stall         (stall),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    //////////////////////////////////////////////////////////////////////
    // EX

    always_comb begin
        case (fwd_a)
            FWD_MEM: ex_a = ex_mem_result;
            FWD_WB:  ex_a = mem_wb_result;
            default: ex_a = id_ex_rs_data;
        endcase
        case (fwd_b)
            FWD_MEM: ex_b_reg = ex_mem_result;
            FWD_WB:  ex_b_reg = mem_wb_result;
            default: ex_b_reg = id_ex_rt_data;
        endcase
    end

    assign ex_b = id_ex_ctrl.alu_src_imm ? id_ex_imm : ex_b_reg;

    alu u_alu (
        .op     (id_ex_ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (ex_result),
        .cond   (ex_cond)
    );

    // Static not-taken; a redirect squashes IF/ID and ID/EX
    assign ex_taken  = id_ex_ctrl.is_jump || (id_ex_ctrl.is_branch && ex_cond);
    assign ex_target = id_ex_ctrl.is_jump
                     ? {id_ex_pc1[`CPU_WORD_SIZE-1:12], id_ex_imm[11:0]}
                     : id_ex_pc1 + id_ex_imm;

    //////////////////////////////////////////////////////////////////////
    // MEM and WB

    assign read_m2  = ex_mem_ctrl.mem_read && !is_halted;
    assign write_m2 = ex_mem_ctrl.mem_write && !is_halted;
    assign address2 = ex_mem_result;
    assign wdata2   = ex_mem_store;

    assign rf.wr_en     = mem_wb_ctrl.reg_write;
    assign rf.wr_addr   = mem_wb_dest;
    assign rf.wr_data   = mem_wb_result;
    assign output_port  = mem_wb_ctrl.wwd ? mem_wb_result : '0;
    assign is_halted    = halted_q || mem_wb_ctrl.halt;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc          <= `CPU_WORD_SIZE'(`CPU_RESET_PC);
            if_id_valid <= 1'b0;
            id_ex_ctrl  <= '0;
            ex_mem_ctrl <= '0;
            mem_wb_ctrl <= '0;
            halted_q    <= 1'b0;
            num_inst    <= '0;
        end else begin
            if (mem_wb_ctrl.halt) begin
                halted_q <= 1'b1;
            end
            // HLT itself is not counted
            if (mem_wb_ctrl != '0 && !mem_wb_ctrl.halt) begin
                num_inst <= num_inst + 1'b1;
            end
            if (is_halted) begin
                mem_wb_ctrl <= '0;
            end else begin
                mem_wb_ctrl <= ex_mem_ctrl;
                ex_mem_ctrl <= id_ex_ctrl;
                if (ex_taken) begin
                    pc          <= ex_target;
                    if_id_valid <= 1'b0;
                    id_ex_ctrl  <= '0;
                end else if (stall) begin
                    id_ex_ctrl  <= '0;
                end else begin
                    pc          <= pc + 1'b1;
                    if_id_valid <= 1'b1;
                    id_ex_ctrl  <= id_ctrl;
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (!is_halted) begin
            if (!stall) begin
                if_id_instr <= instr_t'(data1);
                if_id_pc1   <= pc + 1'b1;
            end
            id_ex_pc1     <= if_id_pc1;
            id_ex_imm     <= id_imm;
            id_ex_rs_data <= rf.rs_data;
            id_ex_rt_data <= rf.rt_data;
            id_ex_rs      <= if_id_instr.i.rs;
            id_ex_rt      <= if_id_instr.i.rt;
            id_ex_dest    <= id_dest;
            ex_mem_result <= ex_result;
            ex_mem_store  <= ex_b_reg;
            ex_mem_dest   <= id_ex_dest;
            mem_wb_result <= ex_mem_ctrl.mem_read ? rdata2 : ex_mem_result;
            mem_wb_dest   <= ex_mem_dest;
        end
    end

    a_mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset_n)
        !(read_m2 && write_m2)
    ) else $error("data port read and write asserted together");

    // Halt is sticky, the PC freezes and no store follows
    a_no_write_halted: assert property (
        @(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted && !write_m2 && $stable(pc)
    ) else $error("core left halt, moved its PC or wrote memory while halted");

endmodule

`default_nettype wire

/* rtl/cpu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu (
    input  logic                      clk,
    input  logic                      reset_n,
    output logic                      read_m1,
    output logic [`CPU_WORD_SIZE-1:0] address1,
    input  logic [`CPU_WORD_SIZE-1:0] data1,
    output logic                      read_m2,
    output logic                      write_m2,
    output logic [`CPU_WORD_SIZE-1:0] address2,
    input  logic [`CPU_WORD_SIZE-1:0] rdata2,
    output logic [`CPU_WORD_SIZE-1:0] wdata2,
    output logic [`CPU_WORD_SIZE-1:0] num_inst,
    output logic [`CPU_WORD_SIZE-1:0] output_port,
    output logic                      is_halted
);

    regfile_if rf_bus ();

    cpu_pipeline u_pipeline (
        .clk         (clk),
        .reset_n     (reset_n),
        .rf          (rf_bus.pipe_side),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .rdata2      (rdata2),
        .wdata2      (wdata2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    register_file u_regfile (
        .clk     (clk),
        .reset_n (reset_n),
        .rf      (rf_bus.reg_side)
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* sim/tb_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;

    import cpu_pkg::*;

    localparam int halt_timeout = 2000;
    localparam int num_random   = 20;

    logic                      clk;
    logic                      reset_n;
    logic                      read_m1;
    logic [`CPU_WORD_SIZE-1:0] address1;
    logic [`CPU_WORD_SIZE-1:0] data1;
    logic                      read_m2;
    logic                      write_m2;
    logic [`CPU_WORD_SIZE-1:0] address2;
    logic [`CPU_WORD_SIZE-1:0] rdata2;
    logic [`CPU_WORD_SIZE-1:0] wdata2;
    logic [`CPU_WORD_SIZE-1:0] num_inst;
    logic [`CPU_WORD_SIZE-1:0] output_port;
    logic                      is_halted;

    logic [15:0] mem [256];
    logic [15:0] prog [$];
    logic [15:0] exp_out [$];
    logic [15:0] exp_st_addr [$];
    logic [15:0] exp_st_data [$];
    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          checks;
    logic        wr_pend = 1'b0;
    logic [7:0]  wr_idx;
    logic [15:0] wr_val;

    tb_clock #(.period_ns(8.0)) u_clock (.clk(clk));

    cpu cpu_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_m1     (read_m1),
        .address1    (address1),
        .data1       (data1),
        .read_m2     (read_m2),
        .write_m2    (write_m2),
        .address2    (address2),
        .rdata2      (rdata2),
        .wdata2      (wdata2),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory model, 256 words, combinational reads

    assign data1  = read_m1 ? mem[address1[7:0]] : '0;
    assign rdata2 = read_m2 ? mem[address2[7:0]] : '0;

    // Store captured mid-cycle lands just after the edge
    always @(posedge clk) begin
        #1;
        if (wr_pend) begin
            mem[wr_idx] = wr_val;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [15:0] enc_r(logic [5:0] fn, logic [1:0] rd, logic [1:0] rs,
                                          logic [1:0] rt);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] enc_i(logic [3:0] op, logic [1:0] rt, logic [1:0] rs,
                                          logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic report_mismatch(input string what, input logic [15:0] exp_val,
                                   input logic [15:0] act_val);
        errors++;
        $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
    endtask

    // Instruction-at-a-time model; fills the expected queues, returns retired count
    function automatic int ref_run();
        logic [15:0] m [256];
        logic [15:0] regs [4];
        logic [15:0] pc;
        logic [15:0] ins;
        logic [15:0] simm;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] ea;
        int          retired;
        int          step;
        m = mem;
        for (int k = 0; k < 4; k++) begin
            regs[k] = '0;
        end
        pc      = '0;
        retired = 0;
        exp_out.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        for (step = 0; step < 1000; step++) begin
            ins  = m[pc[7:0]];
            a    = regs[ins[11:10]];
            b    = regs[ins[9:8]];
            simm = {{8{ins[7]}}, ins[7:0]};
            ea   = a + simm;
            pc   = pc + 16'd1;
            if (ins[15:12] == OP_RTYPE && ins[5:0] == FN_HLT) begin
                return retired;
            end
            retired++;
            case (ins[15:12])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADD: regs[ins[7:6]] = a + b;
                        FN_SUB: regs[ins[7:6]] = a - b;
                        FN_AND: regs[ins[7:6]] = a & b;
                        FN_ORR: regs[ins[7:6]] = a | b;
                        // The port reads 0 outside WWD, so zero values are invisible
                        FN_WWD: if (a != '0) exp_out.push_back(a);
                        default: ;
                    endcase
                end
                OP_ADI: regs[ins[9:8]] = ea;
                OP_LHI: regs[ins[9:8]] = {ins[7:0], 8'h00};
                OP_LWD: regs[ins[9:8]] = m[ea[7:0]];
                OP_SWD: begin
                    m[ea[7:0]] = b;
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                end
                OP_BEQ: if (a == b) pc = pc + simm;
                OP_BNE: if (a != b) pc = pc + simm;
                OP_JMP: pc = {pc[15:12], ins[11:0]};
                default: ;
            endcase
        end
        return retired;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Port checker

    always @(negedge clk) begin
        wr_pend = 1'b0;
        if (reset_n === 1'b0) begin
            if (output_port != '0) begin
                checks++;
                if (exp_out.size() == 0) begin
                    errors++;
                    $display("%s: unexpected output port value %h", test_name, output_port);
                end else begin
                    if (output_port !== exp_out[0]) begin
                        report_mismatch("output_port", exp_out[0], output_port);
                    end
                    void'(exp_out.pop_front());
                end
            end
            if (write_m2 === 1'b1) begin
                wr_pend = 1'b1;
                wr_idx  = address2[7:0];
                wr_val  = wdata2;
                checks++;
                if (exp_st_addr.size() == 0) begin
                    errors++;
                    $display("%s: unexpected store of %h to %h", test_name, wdata2, address2);
                end else begin
                    if (address2 !== exp_st_addr[0]) begin
                        report_mismatch("store address", exp_st_addr[0], address2);
                    end
                    if (wdata2 !== exp_st_data[0]) begin
                        report_mismatch("store data", exp_st_data[0], wdata2);
                    end
                    void'(exp_st_addr.pop_front());
                    void'(exp_st_data.pop_front());
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program runner

    task automatic run_program(input string name);
        int          expected_count;
        int          cycles;
        @(posedge clk);
        #1 reset_n = 1'b1;
        @(posedge clk);
        #1;
        test_name = name;
        for (int k = 0; k < 256; k++) begin
            mem[k] = {8'(k) ^ 8'h5a, 8'(k)};
        end
        for (int k = 0; k < prog.size(); k++) begin
            mem[k] = prog[k];
        end
        expected_count = ref_run();
        repeat (7) @(posedge clk);
        #1 reset_n = 1'b0;
        #1;
        if (read_m2 !== 1'b0) report_mismatch("read_m2 after reset", 16'd0, 16'(read_m2));
        if (write_m2 !== 1'b0) report_mismatch("write_m2 after reset", 16'd0, 16'(write_m2));
        if (is_halted !== 1'b0) report_mismatch("is_halted after reset", 16'd0, 16'(is_halted));
        if (num_inst !== 16'd0) report_mismatch("num_inst after reset", 16'd0, num_inst);

        cycles = 0;
        while (is_halted !== 1'b1 && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (is_halted !== 1'b1) begin
            errors++;
            $display("%s: core did not halt within %0d cycles", name, halt_timeout);
            return;
        end
        checks++;
        if (num_inst !== 16'(expected_count)) begin
            report_mismatch("num_inst at halt", 16'(expected_count), num_inst);
        end
        repeat (10) begin
            @(negedge clk);
            if (num_inst !== 16'(expected_count)) report_mismatch("num_inst after halt",
                                                                  16'(expected_count),
                                                                  num_inst);
            if (write_m2 !== 1'b0) report_mismatch("write_m2 after halt", 16'd0, 16'(write_m2));
        end
        if (exp_out.size() != 0 || exp_st_addr.size() != 0) begin
            errors++;
            $display("%s: %0d port values and %0d stores never appeared", name,
                     exp_out.size(), exp_st_addr.size());
        end
    endtask

    task automatic build_random();
        logic [31:0] r;
        logic [1:0]  ra;
        logic [1:0]  rb;
        logic [1:0]  rc;
        prog.delete();
        for (int i = 0; i < 28; i++) begin
            r  = next_rand();
            ra = r[9:8];
            rb = r[11:10];
            rc = r[13:12];
            case (r[2:0])
                3'd0: prog.push_back(enc_i(OP_LHI, ra, rb, r[23:16]));
                3'd1: prog.push_back(enc_i(OP_ADI, ra, rb, r[23:16]));
                3'd2, 3'd3: prog.push_back(enc_r({4'd0, r[5:4]}, ra, rb, rc));
                // Base 0 plus imm F0..FF reaches the data window
                3'd4, 3'd5: begin
                    prog.push_back(enc_i(OP_LHI, rb, 2'd0, 8'h00));
                    prog.push_back(enc_i(r[0] ? OP_SWD : OP_LWD, ra, rb, {4'hf, r[19:16]}));
                end
                3'd6: begin
                    if (i < 25) begin
                        prog.push_back(enc_i(r[3] ? OP_BEQ : OP_BNE, ra, rb,
                                             8'(r[16]) + 8'd1));
                    end else begin
                        prog.push_back(enc_r(FN_WWD, 2'd0, rb, 2'd0));
                    end
                end
                default: prog.push_back(enc_r(FN_WWD, 2'd0, rb, 2'd0));
            endcase
        end
        prog.push_back(enc_r(FN_HLT, 2'd0, 2'd0, 2'd0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        reset_n   = 1'b1;
        errors    = 0;
        checks    = 0;
        rng_state = 32'h8f1b_1ce6;
        test_name = "init";

        // Dependent ALU chain, MEM and WB forwarding
        prog = '{enc_i(OP_LHI, 2'd1, 2'd0, 8'h12), enc_i(OP_ADI, 2'd2, 2'd1, 8'h05),
                 enc_r(FN_WWD, 2'd0, 2'd2, 2'd0), enc_r(FN_ADD, 2'd3, 2'd1, 2'd2),
                 enc_r(FN_WWD, 2'd0, 2'd3, 2'd0), enc_r(FN_SUB, 2'd0, 2'd3, 2'd1),
                 enc_r(FN_WWD, 2'd0, 2'd0, 2'd0), enc_r(FN_AND, 2'd2, 2'd0, 2'd3),
                 enc_r(FN_WWD, 2'd0, 2'd2, 2'd0), enc_r(FN_ORR, 2'd1, 2'd2, 2'd0),
                 enc_r(FN_ADD, 2'd3, 2'd1, 2'd1), enc_r(FN_WWD, 2'd0, 2'd1, 2'd0),
                 enc_r(FN_WWD, 2'd0, 2'd3, 2'd0), enc_i(OP_ADI, 2'd0, 2'd0, 8'hff),
                 enc_r(FN_WWD, 2'd0, 2'd0, 2'd0), enc_r(FN_HLT, 2'd0, 2'd0, 2'd0)};
        run_program("alu_forwarding");

        prog = '{enc_i(OP_LHI, 2'd0, 2'd0, 8'h00), enc_i(OP_ADI, 2'd1, 2'd0, 8'h37),
                 enc_i(OP_SWD, 2'd1, 2'd0, 8'hf3), enc_i(OP_LWD, 2'd2, 2'd0, 8'hf3),
                 enc_r(FN_ADD, 2'd3, 2'd2, 2'd1), enc_r(FN_WWD, 2'd0, 2'd3, 2'd0),
                 enc_i(OP_LWD, 2'd1, 2'd0, 8'hf5), enc_r(FN_WWD, 2'd0, 2'd1, 2'd0),
                 enc_r(FN_HLT, 2'd0, 2'd0, 2'd0)};
        run_program("load_use");

        // WWD and SWD in the shadow of taken branches
        prog = '{enc_i(OP_ADI, 2'd1, 2'd0, 8'h01), enc_i(OP_ADI, 2'd2, 2'd0, 8'h01),
                 enc_i(OP_BEQ, 2'd2, 2'd1, 8'h02), enc_r(FN_WWD, 2'd0, 2'd1, 2'd0),
                 enc_i(OP_SWD, 2'd1, 2'd0, 8'hf0), enc_i(OP_BNE, 2'd2, 2'd1, 8'h02),
                 enc_r(FN_WWD, 2'd0, 2'd2, 2'd0), enc_i(OP_ADI, 2'd3, 2'd0, 8'h07),
                 enc_i(OP_BNE, 2'd3, 2'd1, 8'h01), enc_r(FN_WWD, 2'd0, 2'd3, 2'd0),
                 enc_i(OP_BEQ, 2'd3, 2'd1, 8'h01), enc_r(FN_WWD, 2'd0, 2'd3, 2'd0),
                 {OP_JMP, 12'd15}, enc_r(FN_WWD, 2'd0, 2'd1, 2'd0),
                 enc_i(OP_SWD, 2'd3, 2'd0, 8'hf2), enc_i(OP_SWD, 2'd3, 2'd0, 8'hf1),
                 enc_r(FN_WWD, 2'd0, 2'd3, 2'd0), enc_r(FN_HLT, 2'd0, 2'd0, 2'd0)};
        run_program("branch_flush");

        for (int n = 0; n < num_random; n++) begin
            build_random();
            run_program($sformatf("random_%0d", n));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/regfile_if.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/hazard_forward.sv
rtl/alu.sv
rtl/cpu_pipeline.sv
rtl/cpu.sv
sim/tb_clock.sv
sim/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_cpu

result=$(./obj_dir/Vtb_cpu)
echo "$result"

echo "$result" | grep -qx "STATUS: PASS"
